// File: Bender.yml
package:
  name: decode_stage

sources:
  - hw/isaPkg.sv
  - hw/pipePkg.sv
  - hw/fdPipeReg.sv
  - hw/decodeControl.sv
  - hw/regFile.sv
  - hw/immTargetGen.sv
  - hw/branchResolve.sv
  - hw/decodeStage.sv
  - target: test
    files:
      - testbench/decodeStage_properties.sv
      - testbench/decodeStageTb.sv

// File: hw/branchResolve.sv
// Early branch resolution with memory stage forwarding and fetch redirect
module branchResolve import isaPkg::*, pipePkg::*; (
  input  logic [XLEN-1:0] rd1,
  input  logic [XLEN-1:0] rd2,
  input  fwdBusT          fwd,
  input  ctrlT            ctrl,
  input  logic [XLEN-1:0] pcBranch,
  input  logic [XLEN-1:0] jumpDst,
  output logic [XLEN-1:0] srcA,
  output logic [XLEN-1:0] srcB,
  output redirectT        redirect,
  output logic            flush
);

  logic branchHit;

  // forwarded operands also feed execute
  assign srcA = fwd.forwardA ? fwd.aluOutM : rd1;
  assign srcB = fwd.forwardB ? fwd.aluOutM : rd2;

  always_comb
  begin
    case (ctrl.branch)
      BR_BEQ:  branchHit = (srcA == srcB);
      BR_BNE:  branchHit = (srcA != srcB);
      default: branchHit = 1'b0;
    endcase
  end

  assign redirect.taken  = branchHit | ctrl.jump;
  assign redirect.target = ctrl.jump ? jumpDst : pcBranch;

  // squash the wrong-path instruction already fetched
  assign flush = redirect.taken;

endmodule

// File: hw/decodeControl.sv
// Main decoder turning opcode and funct into the pipeline control bundle
module decodeControl import isaPkg::*, pipePkg::*; (
  input  instrU instr,
  output ctrlT  ctrl
);

  // common shape of every ALU op that writes a register
  function automatic ctrlT aluCtrl(aluOpE op, aluSrcE src, logic toRd);
    ctrlT c;
    c          = '0;
    c.regWrite = 1'b1;
    c.wbSrc    = WB_ALU;
    c.aluOp    = op;
    c.aluSrc   = src;
    c.regDst   = toRd;
    return c;
  endfunction

  always_comb
  begin
    ctrl = '0;  // all inactive unless a case below says otherwise
    case (instr.rView.op)
      OP_RTYPE:
      begin
        case (instr.rView.funct)
          FN_NOP:  ctrl = '0;
          FN_ADD:  ctrl = aluCtrl(ALU_ADD, SRC_REG, 1'b1);
          FN_SUB:  ctrl = aluCtrl(ALU_SUB, SRC_REG, 1'b1);
          FN_AND:  ctrl = aluCtrl(ALU_AND, SRC_REG, 1'b1);
          FN_OR:   ctrl = aluCtrl(ALU_OR, SRC_REG, 1'b1);
          FN_XOR:  ctrl = aluCtrl(ALU_XOR, SRC_REG, 1'b1);
          FN_XNOR: ctrl = aluCtrl(ALU_XNOR, SRC_REG, 1'b1);
          FN_SLT:  ctrl = aluCtrl(ALU_SLT, SRC_REG, 1'b1);
          FN_MULT, FN_MULTU:
          begin
            // result lands in hi/lo, no register write here
            ctrl.wbSrc      = WB_ALU;
            ctrl.multStart  = 1'b1;
            ctrl.multSigned = (instr.rView.funct == FN_MULT);
          end
          FN_MFLO, FN_MFHI:
          begin
            ctrl.regWrite = 1'b1;
            ctrl.wbSrc    = (instr.rView.funct == FN_MFLO) ? WB_LO : WB_HI;
            ctrl.regDst   = 1'b1;
          end
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OP_ADDI: ctrl = aluCtrl(ALU_ADD, SRC_SIGNIMM, 1'b0);
      OP_ANDI: ctrl = aluCtrl(ALU_AND, SRC_ZEROIMM, 1'b0);  // logical imms zero-extend
      OP_ORI:  ctrl = aluCtrl(ALU_OR, SRC_ZEROIMM, 1'b0);
      OP_XORI: ctrl = aluCtrl(ALU_XOR, SRC_ZEROIMM, 1'b0);
      OP_SLTI: ctrl = aluCtrl(ALU_SLT, SRC_SIGNIMM, 1'b0);
      OP_LUI:  ctrl = aluCtrl(ALU_LUI, SRC_SIGNIMM, 1'b0);
      OP_LW:
      begin
        ctrl       = aluCtrl(ALU_ADD, SRC_SIGNIMM, 1'b0);  // address calc
        ctrl.wbSrc = WB_MEM;
      end
      OP_SW:
      begin
        ctrl          = aluCtrl(ALU_ADD, SRC_SIGNIMM, 1'b0);
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b1;
      end
      OP_JAL:
      begin
        // link into r31, selected downstream
        ctrl.regWrite = 1'b1;
        ctrl.wbSrc    = WB_PC;
        ctrl.jump     = 1'b1;
      end
      OP_BEQ, OP_BNE:
      begin
        ctrl.wbSrc  = WB_ALU;
        ctrl.aluOp  = ALU_SLT;
        ctrl.branch = (instr.iView.op == OP_BEQ) ? BR_BEQ : BR_BNE;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// File: hw/decodeStage.sv
// Decode stage top, pipeline register, control decode, register read and branch resolution
module decodeStage import isaPkg::*, pipePkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall,
  input  instrU           instrF,
  input  logic [XLEN-1:0] pcPlus4F,
  input  fwdBusT          fwd,
  input  wbBusT           wb,
  output decodeT          dec,
  output redirectT        redirect
);

  instrU           instrD;
  logic [XLEN-1:0] pcPlus4D;
  ctrlT            ctrl;
  logic [XLEN-1:0] rd1;
  logic [XLEN-1:0] rd2;
  logic [XLEN-1:0] srcA;
  logic [XLEN-1:0] srcB;
  logic [XLEN-1:0] signImm;
  logic [XLEN-1:0] zeroImm;
  logic [XLEN-1:0] pcBranch;
  logic [XLEN-1:0] jumpDst;
  logic            flush;

  fdPipeReg fdReg (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .flush    (flush),
    .instrF   (instrF),
    .pcPlus4F (pcPlus4F),
    .instrD   (instrD),
    .pcPlus4D (pcPlus4D)
  );

  decodeControl ctrlDec (
    .instr (instrD),
    .ctrl  (ctrl)
  );

  regFile regs (
    .clk (clk),
    .rst (rst),
    .rs  (instrD.rView.rs),
    .rt  (instrD.rView.rt),
    .wb  (wb),
    .rd1 (rd1),
    .rd2 (rd2)
  );

  immTargetGen immGen (
    .instr    (instrD),
    .pcPlus4  (pcPlus4D),
    .signImm  (signImm),
    .zeroImm  (zeroImm),
    .pcBranch (pcBranch),
    .jumpDst  (jumpDst)
  );

  branchResolve brRes (
    .rd1      (rd1),
    .rd2      (rd2),
    .fwd      (fwd),
    .ctrl     (ctrl),
    .pcBranch (pcBranch),
    .jumpDst  (jumpDst),
    .srcA     (srcA),
    .srcB     (srcB),
    .redirect (redirect),
    .flush    (flush)
  );

  assign dec = '{
    ctrl:     ctrl,
    rs:       instrD.rView.rs,
    rt:       instrD.rView.rt,
    rd:       instrD.rView.rd,
    srcA:     srcA,
    srcB:     srcB,
    signImm:  signImm,
    zeroImm:  zeroImm,
    pcPlus4:  pcPlus4D,
    pcBranch: pcBranch,
    jumpDst:  jumpDst
  };

endmodule

// File: hw/fdPipeReg.sv
// Fetch to decode pipeline register, holds on stall and drops to a bubble on flush
module fdPipeReg import isaPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall,
  input  logic            flush,
  input  instrU           instrF,
  input  logic [XLEN-1:0] pcPlus4F,
  output instrU           instrD,
  output logic [XLEN-1:0] pcPlus4D
);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      instrD   <= '0;
      pcPlus4D <= '0;
    end
    else if (flush)
    begin
      // zero word decodes as sll r0,r0,0 i.e. nop
      instrD   <= '0;
      pcPlus4D <= '0;
    end
    else if (!stall)
    begin
      instrD   <= instrF;
      pcPlus4D <= pcPlus4F;
    end
  end

endmodule

// File: hw/immTargetGen.sv
// Immediate extension and branch and jump target computation
module immTargetGen import isaPkg::*; (
  input  instrU           instr,
  input  logic [XLEN-1:0] pcPlus4,
  output logic [XLEN-1:0] signImm,
  output logic [XLEN-1:0] zeroImm,
  output logic [XLEN-1:0] pcBranch,
  output logic [XLEN-1:0] jumpDst
);

  logic [IMM_W-1:0]  imm;
  logic [JIDX_W-1:0] jIdx;

  assign imm  = instr.iView.imm;
  assign jIdx = instr[JIDX_W-1:0];  // rs, rt and imm together

  assign signImm = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
  assign zeroImm = {{(XLEN-IMM_W){1'b0}}, imm};

  // word offset, so shift by two before adding
  assign pcBranch = pcPlus4 + {signImm[XLEN-3:0], 2'b00};

  // pseudo-direct, keeps the current 256MB region
  assign jumpDst = {pcPlus4[XLEN-1:JIDX_W+2], jIdx, 2'b00};

endmodule

// File: hw/isaPkg.sv
// ISA package with MIPS opcode and funct encodings, field widths and the instruction word views
package isaPkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int REG_COUNT  = 32;
  localparam int OP_W       = 6;
  localparam int FUNCT_W    = 6;
  localparam int SHAMT_W    = 5;
  localparam int IMM_W      = 16;
  localparam int JIDX_W     = 26;  // jump index, low bits of the word

  // primary opcodes of the supported subset
  typedef enum logic [OP_W-1:0] {
    OP_RTYPE = 6'b000000,
    OP_JAL   = 6'b000011,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDI  = 6'b001000,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_LUI   = 6'b001111,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcodeE;

  // funct field, only meaningful under OP_RTYPE
  typedef enum logic [FUNCT_W-1:0] {
    FN_NOP   = 6'b000000,
    FN_MFHI  = 6'b010000,
    FN_MFLO  = 6'b010010,
    FN_MULT  = 6'b011000,
    FN_MULTU = 6'b011001,
    FN_ADD   = 6'b100000,
    FN_SUB   = 6'b100010,
    FN_AND   = 6'b100100,
    FN_OR    = 6'b100101,
    FN_XOR   = 6'b100110,
    FN_XNOR  = 6'b100111,
    FN_SLT   = 6'b101010
  } functE;

  typedef struct packed {
    opcodeE                op;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SHAMT_W-1:0]    shamt;
    functE                 funct;
  } rFieldsT;

  typedef struct packed {
    opcodeE                op;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [IMM_W-1:0]      imm;
  } iFieldsT;

  // same word, decoded as R-type or as I/J-type
  typedef union packed {
    rFieldsT rView;
    iFieldsT iView;
  } instrU;

endpackage

// File: hw/pipePkg.sv
// Pipeline package with the decode control bundle and the buses exchanged with other stages
package pipePkg;
  import isaPkg::*;

  typedef enum logic [2:0] {
    ALU_AND  = 3'b000,
    ALU_OR   = 3'b001,
    ALU_ADD  = 3'b010,
    ALU_XOR  = 3'b011,
    ALU_XNOR = 3'b100,
    ALU_SUB  = 3'b101,
    ALU_SLT  = 3'b110,
    ALU_LUI  = 3'b111
  } aluOpE;

  // writeback mux select, PC is the all-zero code
  typedef enum logic [2:0] {
    WB_PC  = 3'b000,
    WB_ALU = 3'b010,
    WB_MEM = 3'b011,
    WB_LO  = 3'b100,
    WB_HI  = 3'b110
  } wbSrcE;

  typedef enum logic [1:0] {
    SRC_REG     = 2'b00,
    SRC_SIGNIMM = 2'b01,
    SRC_ZEROIMM = 2'b10
  } aluSrcE;

  typedef enum logic [1:0] {
    BR_NONE = 2'b00,
    BR_BEQ  = 2'b01,
    BR_BNE  = 2'b10
  } branchE;

  typedef struct packed {
    logic   regWrite;
    wbSrcE  wbSrc;
    logic   memWrite;
    aluOpE  aluOp;
    aluSrcE aluSrc;
    logic   regDst;      // 1 selects rd, 0 selects rt
    branchE branch;
    logic   jump;
    logic   multStart;
    logic   multSigned;
    logic   illegal;
  } ctrlT;

  typedef struct packed {
    logic                  regWrite;
    logic [REG_ADDR_W-1:0] writeReg;
    logic [XLEN-1:0]       result;
  } wbBusT;

  typedef struct packed {
    logic            forwardA;
    logic            forwardB;
    logic [XLEN-1:0] aluOutM;  // memory stage ALU result
  } fwdBusT;

  typedef struct packed {
    ctrlT                  ctrl;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       srcA;
    logic [XLEN-1:0]       srcB;
    logic [XLEN-1:0]       signImm;
    logic [XLEN-1:0]       zeroImm;
    logic [XLEN-1:0]       pcPlus4;
    logic [XLEN-1:0]       pcBranch;
    logic [XLEN-1:0]       jumpDst;
  } decodeT;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirectT;

endpackage

// File: hw/regFile.sv
// Register file with 32 words, two combinational read ports and one clocked write port
module regFile import isaPkg::*, pipePkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] rs,
  input  logic [REG_ADDR_W-1:0] rt,
  input  wbBusT                 wb,
  output logic [XLEN-1:0]       rd1,
  output logic [XLEN-1:0]       rd2
);

  logic [XLEN-1:0] regs [REG_COUNT];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb.regWrite)
    begin
      regs[wb.writeReg] <= wb.result;  // r0 may be written, reads mask it
    end
  end

  // no write-through, new data shows up next cycle
  assign rd1 = (rs == '0) ? '0 : regs[rs];
  assign rd2 = (rt == '0) ? '0 : regs[rt];

endmodule

// File: testbench/decodeStageTb.sv
// Testbench for the decode stage, applies a stimulus table and checks the decoded bundle
module decodeStageTb import isaPkg::*, pipePkg::*; ();

  typedef logic [XLEN-1:0] wordT;
  typedef logic [REG_ADDR_W-1:0] regIdxT;

  typedef struct {
    string    name;
    instrU    instrF;
    wordT     pcPlus4F;
    logic     stall;
    fwdBusT   fwd;
    wbBusT    wb;
    ctrlT     ctrl;
    regIdxT   rs;
    regIdxT   rt;
    regIdxT   rd;
    wordT     pcPlus4;
    wordT     srcA;
    wordT     srcB;
    wordT     signImm;
    wordT     zeroImm;
    wordT     pcBranch;
    wordT     jumpDst;
    redirectT redirect;
  } entryT;

  localparam int RESET_CYCLES = 3;

  // expected control bundles, field order as in ctrlT
  localparam ctrlT ctlNop  = '0;
  localparam ctrlT ctlAdd  = '{1, WB_ALU, 0, ALU_ADD, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlSub  = '{1, WB_ALU, 0, ALU_SUB, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlAnd  = '{1, WB_ALU, 0, ALU_AND, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlXor  = '{1, WB_ALU, 0, ALU_XOR, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlSlt  = '{1, WB_ALU, 0, ALU_SLT, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlXnor = '{1, WB_ALU, 0, ALU_XNOR, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlOr   = '{1, WB_ALU, 0, ALU_OR, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlAddi = '{1, WB_ALU, 0, ALU_ADD, SRC_SIGNIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlAndi = '{1, WB_ALU, 0, ALU_AND, SRC_ZEROIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlOri  = '{1, WB_ALU, 0, ALU_OR, SRC_ZEROIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlXori = '{1, WB_ALU, 0, ALU_XOR, SRC_ZEROIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlSlti = '{1, WB_ALU, 0, ALU_SLT, SRC_SIGNIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlLui  = '{1, WB_ALU, 0, ALU_LUI, SRC_SIGNIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlLw   = '{1, WB_MEM, 0, ALU_ADD, SRC_SIGNIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlSw   = '{0, WB_ALU, 1, ALU_ADD, SRC_SIGNIMM, 0, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlMult = '{0, WB_ALU, 0, ALU_AND, SRC_REG, 0, BR_NONE, 0, 1, 1, 0};
  localparam ctrlT ctlMultu = '{0, WB_ALU, 0, ALU_AND, SRC_REG, 0, BR_NONE, 0, 1, 0, 0};
  localparam ctrlT ctlMfhi = '{1, WB_HI, 0, ALU_AND, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlMflo = '{1, WB_LO, 0, ALU_AND, SRC_REG, 1, BR_NONE, 0, 0, 0, 0};
  localparam ctrlT ctlBeq  = '{0, WB_ALU, 0, ALU_SLT, SRC_REG, 0, BR_BEQ, 0, 0, 0, 0};
  localparam ctrlT ctlBne  = '{0, WB_ALU, 0, ALU_SLT, SRC_REG, 0, BR_BNE, 0, 0, 0, 0};
  localparam ctrlT ctlJal  = '{1, WB_PC, 0, ALU_AND, SRC_REG, 0, BR_NONE, 1, 0, 0, 0};
  localparam ctrlT ctlIll  = '{0, WB_PC, 0, ALU_AND, SRC_REG, 0, BR_NONE, 0, 0, 0, 1};

  logic     clk;
  logic     rst;
  logic     stall;
  instrU    instrF;
  wordT     pcPlus4F;
  fwdBusT   fwd;
  wbBusT    wb;
  decodeT   dec;
  redirectT redirect;

  entryT    entries[$];
  wordT     regModel[REG_COUNT];  // expected register contents
  int       seed = 7599;
  int       cycles = 0;
  int       maxCycles = 1000;
  wordT     vA;
  wordT     vB;
  wordT     vC;
  wordT     vM;

  decodeStage uut (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .instrF   (instrF),
    .pcPlus4F (pcPlus4F),
    .fwd      (fwd),
    .wb       (wb),
    .dec      (dec),
    .redirect (redirect)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > maxCycles)
    begin
      $display("timeout, the table did not finish within %0d cycles", maxCycles);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  function automatic wbBusT wbWrite(int r, wordT val);
    return '{1'b1, r[REG_ADDR_W-1:0], val};
  endfunction

  function automatic fwdBusT fwdSel(logic a, logic b, wordT val);
    return '{a, b, val};
  endfunction

  // decW and dPc are what decode should hold, operands come from the register model
  task automatic addEntry(string nm, instrU ins, wordT pc, logic st, fwdBusT fw, wbBusT w,
                          instrU decW, ctrlT c, wordT dPc, wordT sImm, wordT zImm, wordT pcB,
                          wordT jDst, logic tk, wordT tgt);
    entryT e;
    if (w.regWrite && w.writeReg != 0)
      regModel[w.writeReg] = w.result;  // r0 stays zero
    e.name = nm;
    e.instrF = ins;
    e.pcPlus4F = pc;
    e.stall = st;
    e.fwd = fw;
    e.wb = w;
    e.ctrl = c;
    e.rs = decW.rView.rs;
    e.rt = decW.rView.rt;
    e.rd = decW.rView.rd;
    e.pcPlus4 = dPc;
    e.srcA = fw.forwardA ? fw.aluOutM : regModel[decW.rView.rs];
    e.srcB = fw.forwardB ? fw.aluOutM : regModel[decW.rView.rt];
    e.signImm = sImm;
    e.zeroImm = zImm;
    e.pcBranch = pcB;
    e.jumpDst = jDst;
    e.redirect = '{tk, tgt};
    entries.push_back(e);
  endtask

  task automatic checkCtrl(string nm, ctrlT exp, ctrlT act);
    if (act !== exp)
    begin
      $display("FAIL %s ctrl: expected %h actual %h", nm, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic checkWord(string nm, wordT exp, wordT act);
    if (act !== exp)
    begin
      $display("FAIL %s: expected %h actual %h", nm, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic checkRegIdx(string nm, regIdxT exp, regIdxT act);
    if (act !== exp)
    begin
      $display("FAIL %s: expected %0d actual %0d", nm, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic checkRedirect(string nm, redirectT exp, redirectT act);
    if (act !== exp)
    begin
      $display("FAIL %s redirect: expected %h actual %h", nm, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic checkEntry(entryT e);
    checkCtrl(e.name, e.ctrl, dec.ctrl);
    checkRegIdx({e.name, " rs"}, e.rs, dec.rs);
    checkRegIdx({e.name, " rt"}, e.rt, dec.rt);
    checkRegIdx({e.name, " rd"}, e.rd, dec.rd);
    checkWord({e.name, " pcPlus4"}, e.pcPlus4, dec.pcPlus4);
    checkWord({e.name, " srcA"}, e.srcA, dec.srcA);
    checkWord({e.name, " srcB"}, e.srcB, dec.srcB);
    checkWord({e.name, " signImm"}, e.signImm, dec.signImm);
    checkWord({e.name, " zeroImm"}, e.zeroImm, dec.zeroImm);
    checkWord({e.name, " pcBranch"}, e.pcBranch, dec.pcBranch);
    checkWord({e.name, " jumpDst"}, e.jumpDst, dec.jumpDst);
    checkRedirect(e.name, e.redirect, redirect);
  endtask

  initial
  begin
    clk = 0;
    rst = 1;
    stall = 0;
    instrF = '0;
    pcPlus4F = '0;
    fwd = '0;
    wb = '0;
    for (int i = 0; i < REG_COUNT; i++)
      regModel[i] = '0;
    vA = $random(seed);
    vB = ~vA;
    vC = $random(seed);
    vM = vA ^ 32'h10;  // always differs from vA

    addEntry("add", 32'h00221820, 32'h104, 0, '0, wbWrite(1, vA), 32'h00221820, ctlAdd,
             32'h104, 32'h1820, 32'h1820, 32'h6184, 32'h00886080, 0, 32'h6184);
    addEntry("sub", 32'h00412022, 32'h108, 0, '0, wbWrite(2, vA), 32'h00412022, ctlSub,
             32'h108, 32'h2022, 32'h2022, 32'h8190, 32'h01048088, 0, 32'h8190);
    addEntry("xnor", 32'h00602827, 32'h10C, 0, '0, wbWrite(3, vB), 32'h00602827, ctlXnor,
             32'h10C, 32'h2827, 32'h2827, 32'hA1A8, 32'h0180A09C, 0, 32'hA1A8);
    addEntry("r0 write", 32'h00003025, 32'h110, 0, '0, wbWrite(0, vC), 32'h00003025, ctlOr,
             32'h110, 32'h3025, 32'h3025, 32'hC1A4, 32'h0000C094, 0, 32'hC1A4);
    addEntry("addi neg", 32'h2027FFFC, 32'h200, 0, '0, '0, 32'h2027FFFC, ctlAddi,
             32'h200, 32'hFFFFFFFC, 32'h0000FFFC, 32'h1F0, 32'h009FFFF0, 0, 32'h1F0);
    addEntry("ori", 32'h34488001, 32'h204, 0, '0, '0, 32'h34488001, ctlOri,
             32'h204, 32'hFFFF8001, 32'h00008001, 32'hFFFE0208, 32'h01220004, 0, 32'hFFFE0208);
    addEntry("lw", 32'h8C690010, 32'h208, 0, '0, '0, 32'h8C690010, ctlLw,
             32'h208, 32'h10, 32'h10, 32'h248, 32'h01A40040, 0, 32'h248);
    addEntry("sw", 32'hAC410008, 32'h20C, 0, '0, '0, 32'hAC410008, ctlSw,
             32'h20C, 32'h8, 32'h8, 32'h22C, 32'h01040020, 0, 32'h22C);
    addEntry("mult", 32'h00230018, 32'h210, 0, '0, '0, 32'h00230018, ctlMult,
             32'h210, 32'h18, 32'h18, 32'h270, 32'h008C0060, 0, 32'h270);
    addEntry("mfhi", 32'h00005010, 32'h214, 0, '0, '0, 32'h00005010, ctlMfhi,
             32'h214, 32'h5010, 32'h5010, 32'h14254, 32'h00014040, 0, 32'h14254);
    addEntry("multu", 32'h00220019, 32'h218, 0, '0, '0, 32'h00220019, ctlMultu,
             32'h218, 32'h19, 32'h19, 32'h27C, 32'h00880064, 0, 32'h27C);
    addEntry("mflo", 32'h00005812, 32'h21C, 0, '0, '0, 32'h00005812, ctlMflo,
             32'h21C, 32'h5812, 32'h5812, 32'h16264, 32'h00016048, 0, 32'h16264);
    addEntry("and", 32'h00436024, 32'h220, 0, '0, '0, 32'h00436024, ctlAnd,
             32'h220, 32'h6024, 32'h6024, 32'h182B0, 32'h010D8090, 0, 32'h182B0);
    addEntry("xor", 32'h00616826, 32'h224, 0, '0, '0, 32'h00616826, ctlXor,
             32'h224, 32'h6826, 32'h6826, 32'h1A2BC, 32'h0185A098, 0, 32'h1A2BC);
    addEntry("slt", 32'h0023702A, 32'h228, 0, '0, '0, 32'h0023702A, ctlSlt,
             32'h228, 32'h702A, 32'h702A, 32'h1C2D0, 32'h008DC0A8, 0, 32'h1C2D0);
    addEntry("andi", 32'h30458421, 32'h22C, 0, '0, '0, 32'h30458421, ctlAndi,
             32'h22C, 32'hFFFF8421, 32'h00008421, 32'hFFFE12B0, 32'h01161084, 0, 32'hFFFE12B0);
    addEntry("xori", 32'h386600F0, 32'h230, 0, '0, '0, 32'h386600F0, ctlXori,
             32'h230, 32'hF0, 32'hF0, 32'h5F0, 32'h019803C0, 0, 32'h5F0);
    addEntry("slti", 32'h2827FFF0, 32'h234, 0, '0, '0, 32'h2827FFF0, ctlSlti,
             32'h234, 32'hFFFFFFF0, 32'h0000FFF0, 32'h1F4, 32'h009FFFC0, 0, 32'h1F4);
    addEntry("lui", 32'h3C081234, 32'h238, 0, '0, '0, 32'h3C081234, ctlLui,
             32'h238, 32'h1234, 32'h1234, 32'h4B08, 32'h002048D0, 0, 32'h4B08);
    addEntry("beq taken", 32'h1022FFFE, 32'h300, 0, '0, '0, 32'h1022FFFE, ctlBeq,
             32'h300, 32'hFFFFFFFE, 32'h0000FFFE, 32'h2F8, 32'h008BFFF8, 1, 32'h2F8);
    addEntry("flush nop", 32'h00221820, 32'h2FC, 0, '0, '0, 32'h0, ctlNop,
             32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 0, 32'h0);
    addEntry("bne fwdB", 32'h14220004, 32'h400, 0, fwdSel(0, 1, vM), '0, 32'h14220004, ctlBne,
             32'h400, 32'h4, 32'h4, 32'h410, 32'h00880010, 1, 32'h410);
    addEntry("stall flush", 32'h00412022, 32'h414, 1, '0, '0, 32'h0, ctlNop,
             32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 0, 32'h0);
    addEntry("beq fwdA", 32'h10220004, 32'h500, 0, fwdSel(1, 0, vM), '0, 32'h10220004, ctlBeq,
             32'h500, 32'h4, 32'h4, 32'h510, 32'h00880010, 0, 32'h510);
    addEntry("bne equal", 32'h14220004, 32'h504, 0, '0, '0, 32'h14220004, ctlBne,
             32'h504, 32'h4, 32'h4, 32'h514, 32'h00880010, 0, 32'h514);
    addEntry("stall hold", 32'h00221820, 32'h600, 1, '0, '0, 32'h14220004, ctlBne,
             32'h504, 32'h4, 32'h4, 32'h514, 32'h00880010, 0, 32'h514);
    addEntry("jal", 32'h0C040010, 32'h40000010, 0, '0, '0, 32'h0C040010, ctlJal,
             32'h40000010, 32'h10, 32'h10, 32'h40000050, 32'h40100040, 1, 32'h40100040);
    addEntry("after jal", 32'h00412022, 32'h40000014, 0, '0, '0, 32'h0, ctlNop,
             32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 0, 32'h0);
    addEntry("illegal", 32'hFC000000, 32'h700, 0, '0, '0, 32'hFC000000, ctlIll,
             32'h700, 32'h0, 32'h0, 32'h700, 32'h0, 0, 32'h700);
    maxCycles = entries.size() + RESET_CYCLES + 10;

    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    rst = 0;
    #1;
    checkCtrl("reset", ctlNop, dec.ctrl);
    checkWord("reset srcA", '0, dec.srcA);
    checkWord("reset srcB", '0, dec.srcB);
    checkRedirect("reset", '{1'b0, 32'h0}, redirect);

    // entry i is driven in the cycle where entry i-1 sits in decode
    for (int i = 0; i <= entries.size(); i++)
    begin
      @(posedge clk);
      #10;
      if (i < entries.size())
      begin
        instrF = entries[i].instrF;
        pcPlus4F = entries[i].pcPlus4F;
        stall = entries[i].stall;
        wb = entries[i].wb;
      end
      else
      begin
        instrF = '0;
        stall = 0;
        wb = '0;
      end
      fwd = (i > 0) ? entries[i-1].fwd : '0;
      #80;
      if (i > 0)
        checkEntry(entries[i-1]);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: testbench/decodeStage_properties.sv
// Bound assertions for flush, stall and reset behavior of the decode stage
module decodeStageProperties import isaPkg::*, pipePkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     stall,
  input logic     flush,
  input instrU    instrD,
  input decodeT   dec,
  input redirectT redirect
);

  // a redirect squashes the next instruction to a bubble
  takenClearsCtrl: assert property (@(posedge clk) disable iff (rst)
    redirect.taken |=> dec.ctrl == '0)
    else $error("control not inactive after a taken redirect");

  stallHolds: assert property (@(posedge clk) disable iff (rst)
    stall && !flush |=> $stable(instrD))
    else $error("decode register changed under stall");

  resetNoTaken: assert property (@(posedge clk)
    rst |-> !redirect.taken)
    else $error("redirect taken during reset");

endmodule

bind decodeStage decodeStageProperties props (
  .clk      (clk),
  .rst      (rst),
  .stall    (stall),
  .flush    (flush),
  .instrD   (instrD),
  .dec      (dec),
  .redirect (redirect)
);

// File: vlog.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/fdPipeReg.sv
hw/decodeControl.sv
hw/regFile.sv
hw/immTargetGen.sv
hw/branchResolve.sv
hw/decodeStage.sv
testbench/decodeStage_properties.sv
testbench/decodeStageTb.sv
